/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int WORD_BYTES = 4;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [WORD_BYTES-1:0] byte_en_t;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_REG_IMM  = 7'b0010011,
    OP_AUIPC    = 7'b0010111,
    OP_STORE    = 7'b0100011,
    OP_REG_REG  = 7'b0110011,
    OP_LUI      = 7'b0110111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic [2:0] funct3;
    word_t      imm;
    alu_op_e    alu_op;
    // operand b comes from the immediate instead of rs2
    logic       b_imm;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       is_lui;
    logic       is_auipc;
    logic       is_halt;
    logic       rd_we;
  } decoded_t;

  // one record per executed instruction
  typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;
  } retire_t;

endpackage

`default_nettype wire

/* logic/rv_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
  input  rv_pkg::word_t    insn_i,
  output rv_pkg::decoded_t dec_o
);

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;
  rv_pkg::decoded_t dec;

  // alt picks sub over add and sra over srl
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    rv_pkg::alu_op_e op;
    case (f3)
      3'b000: op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001: op = rv_pkg::ALU_SLL;
      3'b010: op = rv_pkg::ALU_SLT;
      3'b011: op = rv_pkg::ALU_SLTU;
      3'b100: op = rv_pkg::ALU_XOR;
      3'b101: op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110: op = rv_pkg::ALU_OR;
      default: op = rv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};

  always_comb begin
    dec = '0;
    dec.rs1 = insn_i[19:15];
    dec.rs2 = insn_i[24:20];
    dec.rd = insn_i[11:7];
    dec.funct3 = insn_i[14:12];
    dec.alu_op = rv_pkg::ALU_ADD;
    case (rv_pkg::opcode_e'(insn_i[6:0]))
      rv_pkg::OP_LOAD: begin
        dec.is_load = 1'b1;
        dec.rd_we = 1'b1;
        dec.imm = imm_i;
        dec.b_imm = 1'b1;
      end
      rv_pkg::OP_STORE: begin
        dec.is_store = 1'b1;
        dec.imm = imm_s;
        dec.b_imm = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.imm = imm_b;
      end
      rv_pkg::OP_JALR: begin
        dec.is_jalr = 1'b1;
        dec.rd_we = 1'b1;
        dec.imm = imm_i;
        dec.b_imm = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        dec.is_jal = 1'b1;
        dec.rd_we = 1'b1;
        dec.imm = imm_j;
      end
      rv_pkg::OP_REG_IMM: begin
        dec.rd_we = 1'b1;
        dec.imm = imm_i;
        dec.b_imm = 1'b1;
        // bit 30 is part of the immediate except for shifts right
        dec.alu_op = alu_sel(insn_i[14:12], insn_i[14:12] == 3'b101 && insn_i[30]);
      end
      rv_pkg::OP_REG_REG: begin
        dec.rd_we = 1'b1;
        dec.alu_op = alu_sel(insn_i[14:12], insn_i[30]);
      end
      rv_pkg::OP_LUI: begin
        dec.is_lui = 1'b1;
        dec.rd_we = 1'b1;
        dec.imm = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        dec.is_auipc = 1'b1;
        dec.rd_we = 1'b1;
        dec.imm = imm_u;
      end
      // fence has no effect in a core without caches
      rv_pkg::OP_MISC_MEM: begin
      end
      // ecall and any other system encoding both stop the core
      rv_pkg::OP_SYSTEM: dec.is_halt = 1'b1;
      default: dec.is_halt = 1'b1;
    endcase
    if (dec.rd == '0) begin
      dec.rd_we = 1'b0;
    end
  end

  assign dec_o = dec;

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD: result_o = a_i + b_i;
      rv_pkg::ALU_SUB: result_o = a_i - b_i;
      rv_pkg::ALU_SLL: result_o = a_i << shamt;
      rv_pkg::ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      rv_pkg::ALU_SLTU: result_o = {31'b0, a_i < b_i};
      rv_pkg::ALU_XOR: result_o = a_i ^ b_i;
      rv_pkg::ALU_SRL: result_o = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      rv_pkg::ALU_SRA: result_o = $signed(a_i) >>> shamt;
      rv_pkg::ALU_OR: result_o = a_i | b_i;
      rv_pkg::ALU_AND: result_o = a_i & b_i;
      default: result_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o,
  input  logic             we_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  rv_pkg::word_t    rd_data_i
);

  // x0 has no storage
  rv_pkg::word_t regs [31:1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* logic/rv_lsu.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_lsu (
  input  logic [2:0]       funct3_i,
  input  logic             is_store_i,
  input  logic [1:0]       addr_lsb_i,
  input  rv_pkg::word_t    rs2_data_i,
  input  rv_pkg::word_t    rdata_i,
  output rv_pkg::word_t    wdata_o,
  output rv_pkg::byte_en_t we_o,
  output rv_pkg::word_t    load_data_o
);

  rv_pkg::word_t shifted;

  // store data is replicated into every lane, the enables pick the lane
  always_comb begin
    wdata_o = rs2_data_i;
    we_o = '0;
    case (funct3_i[1:0])
      2'b00: begin
        wdata_o = {rv_pkg::WORD_BYTES{rs2_data_i[7:0]}};
        we_o = rv_pkg::byte_en_t'(1) << addr_lsb_i;
      end
      2'b01: begin
        wdata_o = {(rv_pkg::WORD_BYTES / 2){rs2_data_i[15:0]}};
        if (!addr_lsb_i[0]) begin
          we_o = rv_pkg::byte_en_t'(3) << addr_lsb_i;
        end
      end
      2'b10: begin
        if (addr_lsb_i == 2'b00) begin
          we_o = '1;
        end
      end
      default: we_o = '0;
    endcase
    if (!is_store_i) begin
      we_o = '0;
    end
  end

  // addressed byte or halfword moved down to bit 0
  assign shifted = rdata_i >> {addr_lsb_i, 3'b000};

  always_comb begin
    case (funct3_i)
      3'b000: load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      3'b001: load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      3'b100: load_data_o = {24'b0, shifted[7:0]};
      3'b101: load_data_o = {16'b0, shifted[15:0]};
      default: load_data_o = rdata_i;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
  input  logic             clk,
  input  logic             rst,
  output rv_pkg::word_t    imem_addr_o,
  input  rv_pkg::word_t    insn_i,
  output rv_pkg::word_t    dmem_addr_o,
  input  rv_pkg::word_t    dmem_rdata_i,
  output rv_pkg::word_t    dmem_wdata_o,
  output rv_pkg::byte_en_t dmem_we_o,
  output logic             halt_o,
  output rv_pkg::retire_t  retire_o
);

  rv_pkg::word_t pc_q;
  logic halt_q;
  logic exec;
  rv_pkg::decoded_t dec;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t load_data;
  rv_pkg::byte_en_t lsu_we;
  rv_pkg::word_t pc_plus_4;
  rv_pkg::word_t pc_plus_imm;
  rv_pkg::word_t next_pc;
  rv_pkg::word_t wb_data;
  logic taken;

  // an instruction executes only out of reset and before halt
  assign exec = !rst && !halt_q;

  rv_decoder i_decoder (
    .insn_i(insn_i),
    .dec_o (dec)
  );

  rv_regfile i_regfile (
    .clk       (clk),
    .rst       (rst),
    .rs1_i     (dec.rs1),
    .rs2_i     (dec.rs2),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data),
    .we_i      (dec.rd_we && exec),
    .rd_i      (dec.rd),
    .rd_data_i (wb_data)
  );

  assign alu_b = dec.b_imm ? dec.imm : rs2_data;

  rv_alu i_alu (
    .op_i    (dec.alu_op),
    .a_i     (rs1_data),
    .b_i     (alu_b),
    .result_o(alu_result)
  );

  // loads and stores use the ALU sum as the effective address
  rv_lsu i_lsu (
    .funct3_i   (dec.funct3),
    .is_store_i (dec.is_store),
    .addr_lsb_i (alu_result[1:0]),
    .rs2_data_i (rs2_data),
    .rdata_i    (dmem_rdata_i),
    .wdata_o    (dmem_wdata_o),
    .we_o       (lsu_we),
    .load_data_o(load_data)
  );

  assign dmem_addr_o = alu_result & ~rv_pkg::word_t'(rv_pkg::WORD_BYTES - 1);
  assign dmem_we_o = exec ? lsu_we : '0;

  always_comb begin
    case (dec.funct3)
      3'b000: taken = rs1_data == rs2_data;
      3'b001: taken = rs1_data != rs2_data;
      3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110: taken = rs1_data < rs2_data;
      3'b111: taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus_4 = pc_q + rv_pkg::WORD_BYTES;
  assign pc_plus_imm = pc_q + dec.imm;

  always_comb begin
    if (dec.is_halt) begin
      next_pc = pc_q;
    end else if (dec.is_jal || (dec.is_branch && taken)) begin
      next_pc = pc_plus_imm;
    end else if (dec.is_jalr) begin
      next_pc = {alu_result[31:1], 1'b0};
    end else begin
      next_pc = pc_plus_4;
    end
  end

  always_comb begin
    if (dec.is_load) begin
      wb_data = load_data;
    end else if (dec.is_jal || dec.is_jalr) begin
      wb_data = pc_plus_4;
    end else if (dec.is_lui) begin
      wb_data = dec.imm;
    end else if (dec.is_auipc) begin
      wb_data = pc_plus_imm;
    end else begin
      wb_data = alu_result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      pc_q <= next_pc;
      halt_q <= dec.is_halt;
    end
  end

  assign imem_addr_o = pc_q;
  assign halt_o = halt_q;

  assign retire_o.valid = exec;
  assign retire_o.pc = pc_q;
  assign retire_o.rd_we = dec.rd_we;
  assign retire_o.rd = dec.rd;
  assign retire_o.rd_data = wb_data;

endmodule

`default_nettype wire

/* logic/rv_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_memory #(
  parameter int MEM_WORDS = 1024
) (
  input  logic             clk,
  input  rv_pkg::word_t    imem_addr_i,
  output rv_pkg::word_t    insn_o,
  input  rv_pkg::word_t    dmem_addr_i,
  output rv_pkg::word_t    dmem_rdata_o,
  input  rv_pkg::word_t    dmem_wdata_i,
  input  rv_pkg::byte_en_t dmem_we_i,
  input  logic             load_we_i,
  input  rv_pkg::word_t    load_addr_i,
  input  rv_pkg::word_t    load_data_i
);

  localparam int OFFSET_BITS = $clog2(rv_pkg::WORD_BYTES);
  localparam int INDEX_BITS = $clog2(MEM_WORDS);

  rv_pkg::word_t mem [MEM_WORDS];

  logic [INDEX_BITS-1:0] imem_idx;
  logic [INDEX_BITS-1:0] dmem_idx;
  logic [INDEX_BITS-1:0] load_idx;

  // upper address bits beyond the depth wrap around
  assign imem_idx = imem_addr_i[OFFSET_BITS +: INDEX_BITS];
  assign dmem_idx = dmem_addr_i[OFFSET_BITS +: INDEX_BITS];
  assign load_idx = load_addr_i[OFFSET_BITS +: INDEX_BITS];

  // reads see the contents from before this edge's write
  assign insn_o = mem[imem_idx];
  assign dmem_rdata_o = mem[dmem_idx];

  always_ff @(posedge clk) begin
    if (load_we_i) begin
      mem[load_idx] <= load_data_i;
    end else begin
      for (int i = 0; i < rv_pkg::WORD_BYTES; i++) begin
        if (dmem_we_i[i]) begin
          mem[dmem_idx][8*i +: 8] <= dmem_wdata_i[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/rv_system.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system #(
  parameter int MEM_WORDS = 1024
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            load_we_i,
  input  rv_pkg::word_t   load_addr_i,
  input  rv_pkg::word_t   load_data_i,
  output logic            halt_o,
  output rv_pkg::retire_t retire_o
);

  rv_pkg::word_t imem_addr;
  rv_pkg::word_t insn;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_rdata;
  rv_pkg::word_t dmem_wdata;
  rv_pkg::byte_en_t dmem_we;

  rv_core i_rv_core (
    .clk         (clk),
    .rst         (rst),
    .imem_addr_o (imem_addr),
    .insn_i      (insn),
    .dmem_addr_o (dmem_addr),
    .dmem_rdata_i(dmem_rdata),
    .dmem_wdata_o(dmem_wdata),
    .dmem_we_o   (dmem_we),
    .halt_o      (halt_o),
    .retire_o    (retire_o)
  );

  rv_memory #(
    .MEM_WORDS(MEM_WORDS)
  ) i_rv_memory (
    .clk         (clk),
    .imem_addr_i (imem_addr),
    .insn_o      (insn),
    .dmem_addr_i (dmem_addr),
    .dmem_rdata_o(dmem_rdata),
    .dmem_wdata_i(dmem_wdata),
    .dmem_we_i   (dmem_we),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

`default_nettype wire

/* sim/rv_system_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system_chk (
  input logic             clk,
  input logic             rst,
  input rv_pkg::word_t    imem_addr_i,
  input rv_pkg::byte_en_t dmem_we_i,
  input rv_pkg::decoded_t dec_i,
  input logic             halt_i,
  input rv_pkg::retire_t  retire_i
);

  int fail_count = 0;

  // x0 never shows up as a written destination
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    !(retire_i.rd_we && retire_i.rd == '0))
    else begin
      fail_count++;
      $error("x0 reported as written at pc %h", retire_i.pc);
    end

  a_store_only_write: assert property (@(posedge clk)
    !dec_i.is_store |-> dmem_we_i == '0)
    else begin
      fail_count++;
      $error("byte enables %b without a store", dmem_we_i);
    end

  // halt is sticky until the next reset
  a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
    halt_i |=> halt_i)
    else begin
      fail_count++;
      $error("halt dropped without reset");
    end

  a_halt_no_retire: assert property (@(posedge clk)
    halt_i |-> !retire_i.valid)
    else begin
      fail_count++;
      $error("retire valid while halted at pc %h", retire_i.pc);
    end

  a_pc_aligned: assert property (@(posedge clk)
    imem_addr_i[1:0] == 2'b00)
    else begin
      fail_count++;
      $error("instruction address %h not word aligned", imem_addr_i);
    end

endmodule

bind rv_core rv_system_chk i_rv_system_chk (
  .clk        (clk),
  .rst        (rst),
  .imem_addr_i(imem_addr_o),
  .dmem_we_i  (dmem_we_o),
  .dec_i      (dec),
  .halt_i     (halt_o),
  .retire_i   (retire_o)
);

`default_nettype wire

/* sim/rv_system_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_system_tb;

  localparam int MEM_WORDS = 256;
  localparam int RESET_CYCLES = 10;
  localparam int HALT_TIMEOUT = 200;
  localparam int IDLE_CYCLES = 20;
  localparam rv_pkg::word_t ECALL = 32'h00000073;
  // addi x10, x10, 1 marks a path that was executed
  localparam rv_pkg::word_t MARK = 32'h00150513;

  logic clk;
  logic rst;
  logic load_we;
  rv_pkg::word_t load_addr;
  rv_pkg::word_t load_data;
  logic halt;
  rv_pkg::retire_t retire;

  rv_pkg::word_t prog[$];
  rv_pkg::retire_t expected[$];
  rv_pkg::retire_t trace[$];
  int checks;
  int errors;
  int marks;

  rv_system #(
    .MEM_WORDS(MEM_WORDS)
  ) i_rv_system (
    .clk        (clk),
    .rst        (rst),
    .load_we_i  (load_we),
    .load_addr_i(load_addr),
    .load_data_i(load_data),
    .halt_o     (halt),
    .retire_o   (retire)
  );

  always #4 clk = ~clk;

  // RV32I instruction formats
  function automatic rv_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OP_REG_REG};
  endfunction

  function automatic rv_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic rv_pkg::word_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t enc_u(int imm, int rd, logic [6:0] op);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic rv_pkg::word_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OP_JAL};
  endfunction

  function automatic rv_pkg::word_t sext_byte(logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic rv_pkg::word_t zext_byte(logic [7:0] v);
    return {24'b0, v};
  endfunction

  function automatic rv_pkg::word_t sext_half(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic rv_pkg::word_t zext_half(logic [15:0] v);
    return {16'b0, v};
  endfunction

  // byte address of the next instruction to be placed
  function automatic rv_pkg::word_t pc_of_next();
    return rv_pkg::word_t'(4 * prog.size());
  endfunction

  function automatic rv_pkg::retire_t record(rv_pkg::word_t pc, logic we, int rd,
                                             rv_pkg::word_t data);
    rv_pkg::retire_t r;
    r.valid = 1'b1;
    r.pc = pc;
    r.rd_we = we;
    r.rd = rd[4:0];
    r.rd_data = data;
    return r;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(string name, rv_pkg::word_t exp_val, rv_pkg::word_t act_val);
    checks++;
    if (exp_val !== act_val) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
               $time, name, exp_val, act_val);
    end
  endtask

  task automatic new_program(string name);
    $display("test: %s", name);
    prog.delete();
    expected.delete();
    trace.delete();
    marks = 0;
  endtask

  // instruction that retires and writes rd
  task automatic emit_write(rv_pkg::word_t insn, int rd, rv_pkg::word_t data);
    expected.push_back(record(pc_of_next(), 1'b1, rd, data));
    prog.push_back(insn);
  endtask

  // instruction that retires without a register write
  task automatic emit_quiet(rv_pkg::word_t insn);
    expected.push_back(record(pc_of_next(), 1'b0, 0, '0));
    prog.push_back(insn);
  endtask

  // instruction that must never execute
  task automatic emit_skipped(rv_pkg::word_t insn);
    prog.push_back(insn);
  endtask

  // forward branch over one marker instruction
  task automatic emit_branch(int f3, int rs1, int rs2, logic taken);
    emit_quiet(enc_b(8, rs2, rs1, f3));
    if (taken) begin
      emit_skipped(MARK);
    end else begin
      marks++;
      emit_write(MARK, 10, rv_pkg::word_t'(marks));
    end
  endtask

  task automatic load_and_reset();
    tick();
    rst = 1'b1;
    foreach (prog[i]) begin
      load_we = 1'b1;
      load_addr = rv_pkg::word_t'(4 * i);
      load_data = prog[i];
      tick();
    end
    load_we = 1'b0;
    repeat (RESET_CYCLES) tick();
  endtask

  task automatic check_trace();
    int n;
    compare("retire count", rv_pkg::word_t'(expected.size()), rv_pkg::word_t'(trace.size()));
    n = (trace.size() < expected.size()) ? trace.size() : expected.size();
    for (int i = 0; i < n; i++) begin
      compare($sformatf("retire_o.pc[%0d]", i), expected[i].pc, trace[i].pc);
      compare($sformatf("retire_o.rd_we[%0d]", i), rv_pkg::word_t'(expected[i].rd_we),
              rv_pkg::word_t'(trace[i].rd_we));
      if (expected[i].rd_we) begin
        compare($sformatf("retire_o.rd[%0d]", i), rv_pkg::word_t'(expected[i].rd),
                rv_pkg::word_t'(trace[i].rd));
        compare($sformatf("retire_o.rd_data[%0d]", i), expected[i].rd_data,
                trace[i].rd_data);
      end
    end
  endtask

  task automatic run_program();
    int cycles;
    int last_valid;
    int halt_at;
    load_and_reset();
    rst = 1'b0;
    cycles = 0;
    last_valid = -1;
    halt_at = -1;
    // sample mid-cycle, away from the drive edge
    while (halt_at < 0 && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      if (retire.valid) begin
        trace.push_back(retire);
        last_valid = cycles;
      end
      if (halt) begin
        halt_at = cycles;
      end
      cycles++;
    end
    if (halt_at < 0) begin
      errors++;
      $display("ERROR at %0t ns: program did not halt within %0d cycles", $time, HALT_TIMEOUT);
    end else begin
      compare("halt_o delay", 32'd1, rv_pkg::word_t'(halt_at - last_valid));
      repeat (IDLE_CYCLES) begin
        @(negedge clk);
        compare("halt_o", 32'd1, rv_pkg::word_t'(halt));
        compare("retire_o.valid", 32'd0, rv_pkg::word_t'(retire.valid));
      end
    end
    check_trace();
  endtask

  task automatic test_alu();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    a = 32'd100;
    b = 32'hFFFFFFF9;
    new_program("arithmetic and logic");
    emit_write(enc_i(100, 0, 0, 1, rv_pkg::OP_REG_IMM), 1, a);
    emit_write(enc_i(-7, 0, 0, 2, rv_pkg::OP_REG_IMM), 2, b);
    emit_write(enc_r(0, 2, 1, 0, 3), 3, a + b);
    emit_write(enc_r(32, 1, 2, 0, 4), 4, b - a);
    emit_write(enc_r(0, 1, 2, 2, 5), 5, 32'd1);
    emit_write(enc_r(0, 2, 1, 2, 6), 6, 32'd0);
    emit_write(enc_r(0, 1, 2, 3, 7), 7, 32'd0);
    emit_write(enc_i(-6, 2, 2, 8, rv_pkg::OP_REG_IMM), 8, 32'd1);
    emit_write(enc_i(-1, 1, 3, 9, rv_pkg::OP_REG_IMM), 9, 32'd1);
    emit_write(enc_r(0, 2, 1, 4, 10), 10, a ^ b);
    emit_write(enc_r(0, 2, 1, 6, 11), 11, a | b);
    emit_write(enc_r(0, 2, 1, 7, 12), 12, a & b);
    emit_write(enc_i(31, 0, 0, 13, rv_pkg::OP_REG_IMM), 13, 32'd31);
    emit_write(enc_r(0, 13, 2, 1, 14), 14, 32'h80000000);
    emit_write(enc_r(0, 13, 2, 5, 15), 15, 32'h00000001);
    emit_write(enc_r(32, 13, 2, 5, 16), 16, 32'hFFFFFFFF);
    emit_write(enc_i(3, 1, 1, 17, rv_pkg::OP_REG_IMM), 17, 32'd800);
    emit_write(enc_i(4, 2, 5, 18, rv_pkg::OP_REG_IMM), 18, 32'h0FFFFFFF);
    // bit 30 of the immediate selects the arithmetic shift
    emit_write(enc_i(32'h401, 2, 5, 19, rv_pkg::OP_REG_IMM), 19, 32'hFFFFFFFC);
    emit_write(enc_i(-1, 1, 4, 20, rv_pkg::OP_REG_IMM), 20, ~a);
    emit_write(enc_i(15, 1, 6, 21, rv_pkg::OP_REG_IMM), 21, a | 32'h0F);
    emit_write(enc_i(32'hF0, 2, 7, 22, rv_pkg::OP_REG_IMM), 22, b & 32'hF0);
    emit_quiet(ECALL);
    run_program();
  endtask

  task automatic test_upper();
    new_program("lui, auipc and x0");
    emit_write(enc_u(32'h12345, 1, rv_pkg::OP_LUI), 1, 32'h12345000);
    emit_write(enc_u(1, 2, rv_pkg::OP_AUIPC), 2, pc_of_next() + 32'h00001000);
    emit_write(enc_u(32'hFFFFF, 3, rv_pkg::OP_AUIPC), 3, pc_of_next() + 32'hFFFFF000);
    emit_quiet(enc_i(5, 1, 0, 0, rv_pkg::OP_REG_IMM));
    emit_write(enc_r(0, 1, 0, 0, 4), 4, 32'h12345000);
    emit_write(enc_r(0, 0, 2, 0, 5), 5, 32'h00001004);
    emit_quiet(ECALL);
    run_program();
  endtask

  task automatic test_control();
    rv_pkg::word_t p;
    new_program("branches and jumps");
    emit_write(enc_i(5, 0, 0, 1, rv_pkg::OP_REG_IMM), 1, 32'd5);
    emit_write(enc_i(-3, 0, 0, 2, rv_pkg::OP_REG_IMM), 2, 32'hFFFFFFFD);
    emit_write(enc_i(5, 0, 0, 3, rv_pkg::OP_REG_IMM), 3, 32'd5);
    // x1 = 5, x2 = -3, x3 = 5
    emit_branch(0, 1, 3, 1'b1);
    emit_branch(0, 1, 2, 1'b0);
    emit_branch(1, 1, 2, 1'b1);
    emit_branch(1, 1, 3, 1'b0);
    emit_branch(4, 2, 1, 1'b1);
    emit_branch(4, 1, 2, 1'b0);
    emit_branch(5, 1, 2, 1'b1);
    emit_branch(5, 2, 1, 1'b0);
    emit_branch(6, 1, 2, 1'b1);
    emit_branch(6, 2, 1, 1'b0);
    emit_branch(7, 2, 1, 1'b1);
    emit_branch(7, 1, 2, 1'b0);
    p = pc_of_next();
    emit_write(enc_j(12, 5), 5, p + 4);
    emit_skipped(MARK);
    emit_skipped(MARK);
    // odd base address, the jalr target drops bit 0
    emit_write(enc_i(p + 21, 0, 0, 6, rv_pkg::OP_REG_IMM), 6, p + 21);
    emit_write(enc_i(4, 6, 0, 7, rv_pkg::OP_JALR), 7, p + 20);
    emit_skipped(MARK);
    emit_quiet(ECALL);
    run_program();
  endtask

  task automatic test_memory();
    rv_pkg::word_t w0;
    rv_pkg::word_t w1;
    rv_pkg::word_t w2;
    w0 = 32'h89ABCDEF;
    w1 = {16'hFFA4, w0[15:0]};
    w2 = {8'hFF, 8'h7F, 8'h82, 8'h11};
    new_program("loads and stores");
    emit_write(enc_i(32'h200, 0, 0, 1, rv_pkg::OP_REG_IMM), 1, 32'h00000200);
    emit_write(enc_u(32'h89ABD, 2, rv_pkg::OP_LUI), 2, 32'h89ABD000);
    emit_write(enc_i(-32'h211, 2, 0, 2, rv_pkg::OP_REG_IMM), 2, w0);
    emit_quiet(enc_s(0, 2, 1, 2));
    emit_quiet(enc_s(4, 2, 1, 2));
    emit_write(enc_i(-32'h5C, 0, 0, 9, rv_pkg::OP_REG_IMM), 9, 32'hFFFFFFA4);
    emit_quiet(enc_s(6, 9, 1, 1));
    emit_quiet(enc_s(8, 0, 1, 2));
    emit_write(enc_i(32'h11, 0, 0, 11, rv_pkg::OP_REG_IMM), 11, 32'h00000011);
    emit_write(enc_i(-32'h7E, 0, 0, 12, rv_pkg::OP_REG_IMM), 12, 32'hFFFFFF82);
    emit_write(enc_i(32'h7F, 0, 0, 13, rv_pkg::OP_REG_IMM), 13, 32'h0000007F);
    emit_write(enc_i(-1, 0, 0, 14, rv_pkg::OP_REG_IMM), 14, 32'hFFFFFFFF);
    // one byte into each lane of the word at 0x208
    emit_quiet(enc_s(8, 11, 1, 0));
    emit_quiet(enc_s(9, 12, 1, 0));
    emit_quiet(enc_s(10, 13, 1, 0));
    emit_quiet(enc_s(11, 14, 1, 0));
    emit_write(enc_i(0, 1, 2, 3, rv_pkg::OP_LOAD), 3, w0);
    emit_write(enc_i(0, 1, 0, 4, rv_pkg::OP_LOAD), 4, sext_byte(w0[7:0]));
    emit_write(enc_i(1, 1, 4, 5, rv_pkg::OP_LOAD), 5, zext_byte(w0[15:8]));
    emit_write(enc_i(2, 1, 1, 6, rv_pkg::OP_LOAD), 6, sext_half(w0[31:16]));
    emit_write(enc_i(0, 1, 5, 7, rv_pkg::OP_LOAD), 7, zext_half(w0[15:0]));
    emit_write(enc_i(4, 1, 2, 15, rv_pkg::OP_LOAD), 15, w1);
    emit_write(enc_i(6, 1, 1, 16, rv_pkg::OP_LOAD), 16, sext_half(w1[31:16]));
    emit_write(enc_i(6, 1, 5, 17, rv_pkg::OP_LOAD), 17, zext_half(w1[31:16]));
    emit_write(enc_i(4, 1, 5, 18, rv_pkg::OP_LOAD), 18, zext_half(w1[15:0]));
    emit_write(enc_i(8, 1, 2, 19, rv_pkg::OP_LOAD), 19, w2);
    emit_write(enc_i(9, 1, 0, 20, rv_pkg::OP_LOAD), 20, sext_byte(w2[15:8]));
    emit_write(enc_i(9, 1, 4, 21, rv_pkg::OP_LOAD), 21, zext_byte(w2[15:8]));
    emit_write(enc_i(10, 1, 0, 22, rv_pkg::OP_LOAD), 22, sext_byte(w2[23:16]));
    emit_write(enc_i(11, 1, 4, 23, rv_pkg::OP_LOAD), 23, zext_byte(w2[31:24]));
    emit_write(enc_i(11, 1, 0, 24, rv_pkg::OP_LOAD), 24, sext_byte(w2[31:24]));
    emit_write(enc_i(8, 1, 0, 25, rv_pkg::OP_LOAD), 25, sext_byte(w2[7:0]));
    emit_write(enc_i(10, 1, 1, 26, rv_pkg::OP_LOAD), 26, sext_half(w2[31:16]));
    emit_write(enc_i(8, 1, 5, 27, rv_pkg::OP_LOAD), 27, zext_half(w2[15:0]));
    emit_quiet(ECALL);
    run_program();
  endtask

  task automatic test_halt();
    new_program("halt on ecall");
    emit_write(enc_i(1, 0, 0, 1, rv_pkg::OP_REG_IMM), 1, 32'd1);
    emit_quiet(ECALL);
    emit_skipped(enc_i(2, 0, 0, 2, rv_pkg::OP_REG_IMM));
    run_program();
    new_program("halt on illegal opcode");
    emit_write(enc_i(3, 0, 0, 1, rv_pkg::OP_REG_IMM), 1, 32'd3);
    emit_quiet(32'hFFFFFFFF);
    emit_skipped(enc_i(2, 0, 0, 2, rv_pkg::OP_REG_IMM));
    run_program();
  endtask

  initial begin
    int assert_fails;
    clk = 1'b0;
    rst = 1'b1;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    checks = 0;
    errors = 0;
    marks = 0;
    test_alu();
    test_upper();
    test_control();
    test_memory();
    test_halt();
    assert_fails = i_rv_system.i_rv_core.i_rv_system_chk.fail_count;
    $display("checks: %0d, check errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_lsu.sv
logic/rv_core.sv
logic/rv_memory.sv
logic/rv_system.sv
sim/rv_system_chk.sv
sim/rv_system_tb.sv

/* run.sh */
#!/bin/sh
# build and run the RV32I system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_system_tb \
  -f filelist.f -o rv_system_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/rv_system_tb > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1
